/* include/nmcu_consts.svh */
`ifndef NMCU_CONSTS_SVH
`define NMCU_CONSTS_SVH

// external memory bus
`define NMCU_ADDR_W 16
`define NMCU_DATA_W 32

// descriptor list
`define NMCU_MAX_DESCS 8
`define NMCU_DESC_IDX_W 3

// tile side limit, iterators share the width
`define NMCU_MAX_DIM 15
`define NMCU_DIM_W 4

`endif

/* hdl/nmcu_pkg.sv */
`default_nettype none

`include "nmcu_consts.svh"

package nmcu_pkg;

    typedef enum logic [1:0] {
        NOP  = 2'd0,
        RSVD = 2'd1,
        MAXP = 2'd2,
        RELU = 2'd3
    } layer_type_e;

    // descriptor word layout
    typedef struct packed {
        logic [21:0]             reserved;
        logic [`NMCU_DIM_W-1:0]  height;
        logic [`NMCU_DIM_W-1:0]  width;
        layer_type_e             ltype;
    } desc_fields_t;

    // read data is a descriptor or an activation, depending on phase
    typedef union packed {
        desc_fields_t                   desc;
        logic signed [`NMCU_DATA_W-1:0] sample;
    } desc_word_u;

endpackage

`default_nettype wire

/* hdl/nmcu_desc_store.sv */
`default_nettype none

`include "nmcu_consts.svh"

module nmcu_desc_store (
    input  logic                         clk,
    input  logic                         we,
    input  logic [`NMCU_DESC_IDX_W-1:0]  idx,
    input  nmcu_pkg::desc_word_u         wdata,
    output nmcu_pkg::desc_fields_t       cur_desc,
    output nmcu_pkg::desc_fields_t       next_desc
);

    nmcu_pkg::desc_fields_t slots [0:`NMCU_MAX_DESCS-1];

    logic [`NMCU_DESC_IDX_W-1:0] next_idx;

    // wraps at the last slot, which is always terminal
    assign next_idx = idx + 1'b1;

    always_ff @(posedge clk) begin
        if (we) begin
            slots[idx] <= wdata.desc;
        end
    end

    // current layer and the one after it
    assign cur_desc  = slots[idx];
    assign next_desc = slots[next_idx];

endmodule

`default_nettype wire

/* hdl/nmcu_act_buffer.sv */
`default_nettype none

`include "nmcu_consts.svh"

module nmcu_act_buffer (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               we,
    input  logic                               to_spare,
    input  logic [`NMCU_DIM_W-1:0]             wr_row,
    input  logic [`NMCU_DIM_W-1:0]             wr_col,
    input  logic [`NMCU_DATA_W-1:0]            wr_data,
    input  logic [`NMCU_DIM_W-1:0]             rd_row,
    input  logic [`NMCU_DIM_W-1:0]             rd_col,
    input  logic                               swap,
    output logic [3:0][`NMCU_DATA_W-1:0]       win
);

    logic [`NMCU_DATA_W-1:0] bank [0:1][0:`NMCU_MAX_DIM-1][0:`NMCU_MAX_DIM-1];

    logic                    active;
    logic                    wr_bank;
    logic [`NMCU_DIM_W-1:0]  rd_row1;
    logic [`NMCU_DIM_W-1:0]  rd_col1;

    // bank holding the current layer input
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            active <= 1'b0;
        end else if (swap) begin
            active <= ~active;
        end
    end

    assign wr_bank = to_spare ? ~active : active;

    always_ff @(posedge clk) begin
        if (we) begin
            bank[wr_bank][wr_row][wr_col] <= wr_data;
        end
    end

    // lower and right neighbours saturate at the array edge
    // only relu and writeback read there, and they ignore them
    assign rd_row1 = (rd_row == `NMCU_MAX_DIM - 1) ? rd_row : rd_row + 1'b1;
    assign rd_col1 = (rd_col == `NMCU_MAX_DIM - 1) ? rd_col : rd_col + 1'b1;

    // 2x2 window, row-major
    assign win[0] = bank[active][rd_row][rd_col];
    assign win[1] = bank[active][rd_row][rd_col1];
    assign win[2] = bank[active][rd_row1][rd_col];
    assign win[3] = bank[active][rd_row1][rd_col1];

endmodule

`default_nettype wire

/* hdl/nmcu_layer_alu.sv */
`default_nettype none

`include "nmcu_consts.svh"

module nmcu_layer_alu (
    input  logic                          clk,
    input  logic                          rst,
    input  nmcu_pkg::layer_type_e         op,
    input  logic [3:0][`NMCU_DATA_W-1:0]  win,
    output logic [`NMCU_DATA_W-1:0]       result
);

    logic [`NMCU_DATA_W-1:0] top_max;
    logic [`NMCU_DATA_W-1:0] bot_max;
    logic [`NMCU_DATA_W-1:0] pool;
    logic [`NMCU_DATA_W-1:0] relu;

    // signed max over the window, two rows then across
    assign top_max = ($signed(win[0]) > $signed(win[1])) ? win[0] : win[1];
    assign bot_max = ($signed(win[2]) > $signed(win[3])) ? win[2] : win[3];
    assign pool    = ($signed(top_max) > $signed(bot_max)) ? top_max : bot_max;

    // relu on the upper left sample only
    assign relu = win[0][`NMCU_DATA_W-1] ? '0 : win[0];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            result <= '0;
        end else begin
            result <= (op == nmcu_pkg::MAXP) ? pool : relu;
        end
    end

endmodule

`default_nettype wire

/* hdl/nmcu_ctrl.sv */
`default_nettype none

`include "nmcu_consts.svh"

module nmcu_ctrl (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          start,
    output logic                          done,
    input  logic [`NMCU_ADDR_W-1:0]       desc_addr,
    input  logic [`NMCU_ADDR_W-1:0]       input_addr,
    input  logic [`NMCU_ADDR_W-1:0]       output_addr,
    input  logic [`NMCU_DIM_W-1:0]        full_input_width,
    output logic [`NMCU_ADDR_W-1:0]       addr,
    output logic                          mem_sel,
    output logic                          mem_w,
    output logic [`NMCU_DATA_W-1:0]       wr_data,
    input  nmcu_pkg::desc_word_u          rd_data,
    input  logic                          ready,
    output logic                          desc_we,
    output logic [`NMCU_DESC_IDX_W-1:0]   desc_idx,
    input  nmcu_pkg::desc_fields_t        cur_desc,
    input  nmcu_pkg::desc_fields_t        next_desc,
    output logic                          buf_we,
    output logic                          buf_to_spare,
    output logic [`NMCU_DIM_W-1:0]        buf_row,
    output logic [`NMCU_DIM_W-1:0]        buf_col,
    output logic [`NMCU_DATA_W-1:0]       buf_wdata,
    output logic [`NMCU_DIM_W-1:0]        rd_row,
    output logic [`NMCU_DIM_W-1:0]        rd_col,
    output logic                          swap,
    input  logic [3:0][`NMCU_DATA_W-1:0]  win,
    output nmcu_pkg::layer_type_e         alu_op,
    input  logic [`NMCU_DATA_W-1:0]       alu_result
);

    typedef enum logic [2:0] {
        IDLE,
        READ_DESCS,
        READ_INPUTS,
        RUN_LAYER,
        WRITEBACK,
        FINISHED
    } state_t;

    state_t                        state;
    logic [`NMCU_DESC_IDX_W-1:0]   idx;
    logic [`NMCU_DIM_W-1:0]        row;
    logic [`NMCU_DIM_W-1:0]        col;
    logic                          half;
    logic                          xfer;
    logic                          is_pool;
    logic                          next_term;
    logic [`NMCU_DIM_W-1:0]        it_w;
    logic [`NMCU_DIM_W-1:0]        it_h;
    logic                          col_last;
    logic                          row_last;
    logic [`NMCU_ADDR_W-1:0]       row_step;

    // nop and rsvd both end the list
    function automatic logic is_term(input nmcu_pkg::layer_type_e t);
        return (t == nmcu_pkg::NOP) || (t == nmcu_pkg::RSVD);
    endfunction

    assign xfer    = mem_sel && ready;
    assign is_pool = (state == RUN_LAYER) && (cur_desc.ltype == nmcu_pkg::MAXP);

    // slot 7 terminates even without a terminal type
    assign next_term = is_term(next_desc.ltype) ||
                       (idx == `NMCU_DESC_IDX_W'(`NMCU_MAX_DESCS - 2));

    // pooling iterates over the output shape, given by the next descriptor
    assign it_w     = is_pool ? next_desc.width : cur_desc.width;
    assign it_h     = is_pool ? next_desc.height : cur_desc.height;
    assign col_last = (col == it_w - 1'b1);
    assign row_last = (row == it_h - 1'b1);

    // jump from the end of a tile row to the start of the next image row
    assign row_step = `NMCU_ADDR_W'(full_input_width) - `NMCU_ADDR_W'(cur_desc.width) + 1'b1;

    assign desc_idx = idx;
    assign alu_op   = cur_desc.ltype;

    always_comb begin
        desc_we      = (state == READ_DESCS) && xfer;
        buf_we       = ((state == READ_INPUTS) && xfer) || ((state == RUN_LAYER) && half);
        buf_to_spare = (state == RUN_LAYER);
        buf_row      = row;
        buf_col      = col;
        buf_wdata    = (state == READ_INPUTS) ? rd_data.sample : alu_result;
        swap         = (state == RUN_LAYER) && half && col_last && row_last;
        rd_row       = is_pool ? (row << 1) : row;
        rd_col       = is_pool ? (col << 1) : col;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= IDLE;
            idx     <= '0;
            row     <= '0;
            col     <= '0;
            half    <= 1'b0;
            addr    <= '0;
            mem_sel <= 1'b0;
            mem_w   <= 1'b0;
            done    <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        addr    <= desc_addr;
                        idx     <= '0;
                        mem_sel <= 1'b1;
                        state   <= READ_DESCS;
                    end
                end
                READ_DESCS: begin
                    // a low mem_sel here is the stall cycle after a transfer
                    if (!mem_sel) begin
                        mem_sel <= 1'b1;
                    end else if (ready) begin
                        mem_sel <= 1'b0;
                        if (is_term(rd_data.desc.ltype) ||
                            idx == `NMCU_DESC_IDX_W'(`NMCU_MAX_DESCS - 1)) begin
                            idx   <= '0;
                            row   <= '0;
                            col   <= '0;
                            addr  <= input_addr;
                            state <= READ_INPUTS;
                        end else begin
                            idx  <= idx + 1'b1;
                            addr <= addr + 1'b1;
                        end
                    end
                end
                READ_INPUTS: begin
                    if (!mem_sel) begin
                        mem_sel <= 1'b1;
                    end else if (ready) begin
                        mem_sel <= 1'b0;
                        if (!col_last) begin
                            col  <= col + 1'b1;
                            addr <= addr + 1'b1;
                        end else if (!row_last) begin
                            col  <= '0;
                            row  <= row + 1'b1;
                            addr <= addr + row_step;
                        end else begin
                            col   <= '0;
                            row   <= '0;
                            addr  <= output_addr;
                            state <= is_term(cur_desc.ltype) ? WRITEBACK : RUN_LAYER;
                        end
                    end
                end
                RUN_LAYER: begin
                    // first half presents the window, second half stores the result
                    half <= ~half;
                    if (half) begin
                        if (!col_last) begin
                            col <= col + 1'b1;
                        end else if (!row_last) begin
                            col <= '0;
                            row <= row + 1'b1;
                        end else begin
                            col <= '0;
                            row <= '0;
                            idx <= idx + 1'b1;
                            if (next_term) begin
                                state <= WRITEBACK;
                            end
                        end
                    end
                end
                WRITEBACK: begin
                    if (!mem_sel) begin
                        mem_sel <= 1'b1;
                        mem_w   <= 1'b1;
                    end else if (ready) begin
                        mem_sel <= 1'b0;
                        mem_w   <= 1'b0;
                        addr    <= addr + 1'b1;
                        if (!col_last) begin
                            col <= col + 1'b1;
                        end else if (!row_last) begin
                            col <= '0;
                            row <= row + 1'b1;
                        end else begin
                            state <= FINISHED;
                        end
                    end
                end
                FINISHED: begin
                    done <= 1'b1;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // latched as the write request is raised, held until accepted
    always_ff @(posedge clk) begin
        if (state == WRITEBACK && !mem_sel) begin
            wr_data <= win[0];
        end
    end

endmodule

`default_nettype wire

/* hdl/nmcu_top.sv */
`default_nettype none

`include "nmcu_consts.svh"

module nmcu_top (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     start,
    output logic                     done,
    input  logic [`NMCU_ADDR_W-1:0]  desc_addr,
    input  logic [`NMCU_ADDR_W-1:0]  input_addr,
    input  logic [`NMCU_ADDR_W-1:0]  output_addr,
    input  logic [`NMCU_DIM_W-1:0]   full_input_width,
    output logic [`NMCU_ADDR_W-1:0]  addr,
    output logic                     mem_sel,
    output logic                     mem_w,
    output logic [`NMCU_DATA_W-1:0]  wr_data,
    input  nmcu_pkg::desc_word_u     rd_data,
    input  logic                     ready
);

    logic                           desc_we;
    logic [`NMCU_DESC_IDX_W-1:0]    desc_idx;
    nmcu_pkg::desc_fields_t         cur_desc;
    nmcu_pkg::desc_fields_t         next_desc;
    logic                           buf_we;
    logic                           buf_to_spare;
    logic [`NMCU_DIM_W-1:0]         buf_row;
    logic [`NMCU_DIM_W-1:0]         buf_col;
    logic [`NMCU_DATA_W-1:0]        buf_wdata;
    logic [`NMCU_DIM_W-1:0]         rd_row;
    logic [`NMCU_DIM_W-1:0]         rd_col;
    logic                           swap;
    logic [3:0][`NMCU_DATA_W-1:0]   win;
    nmcu_pkg::layer_type_e          alu_op;
    logic [`NMCU_DATA_W-1:0]        alu_result;

    nmcu_ctrl u_ctrl (
        .clk(clk), .rst(rst), .start(start), .done(done),
        .desc_addr(desc_addr), .input_addr(input_addr), .output_addr(output_addr),
        .full_input_width(full_input_width),
        .addr(addr), .mem_sel(mem_sel), .mem_w(mem_w), .wr_data(wr_data),
        .rd_data(rd_data), .ready(ready),
        .desc_we(desc_we), .desc_idx(desc_idx),
        .cur_desc(cur_desc), .next_desc(next_desc),
        .buf_we(buf_we), .buf_to_spare(buf_to_spare),
        .buf_row(buf_row), .buf_col(buf_col), .buf_wdata(buf_wdata),
        .rd_row(rd_row), .rd_col(rd_col), .swap(swap), .win(win),
        .alu_op(alu_op), .alu_result(alu_result)
    );

    // descriptor words come straight off the read bus
    nmcu_desc_store u_desc_store (
        .clk(clk), .we(desc_we), .idx(desc_idx), .wdata(rd_data),
        .cur_desc(cur_desc), .next_desc(next_desc)
    );

    nmcu_act_buffer u_act_buffer (
        .clk(clk), .rst(rst), .we(buf_we), .to_spare(buf_to_spare),
        .wr_row(buf_row), .wr_col(buf_col), .wr_data(buf_wdata),
        .rd_row(rd_row), .rd_col(rd_col), .swap(swap), .win(win)
    );

    nmcu_layer_alu u_layer_alu (
        .clk(clk), .rst(rst), .op(alu_op), .win(win), .result(alu_result)
    );

endmodule

`default_nettype wire

/* sim/nmcu_sva.sv */
`default_nettype none

`include "nmcu_consts.svh"

module nmcu_sva (
    input logic                    clk,
    input logic                    rst,
    input logic                    mem_sel,
    input logic                    mem_w,
    input logic                    ready,
    input logic [`NMCU_ADDR_W-1:0] addr,
    input logic                    done
);

    timeunit 1ns;
    timeprecision 100ps;

    // a write is always part of a request
    write_in_request: assert property (@(posedge clk) disable iff (rst)
        mem_w |-> mem_sel)
        else $error("mem_w high without mem_sel");

    // one idle cycle after every transfer
    stall_after_transfer: assert property (@(posedge clk) disable iff (rst)
        mem_sel && ready |=> !mem_sel)
        else $error("mem_sel not dropped after a transfer");

    addr_held: assert property (@(posedge clk) disable iff (rst)
        mem_sel && !ready |=> $stable(addr))
        else $error("addr changed during a stalled request");

    done_sticky: assert property (@(posedge clk) disable iff (rst)
        done |=> done)
        else $error("done fell without reset");

endmodule

bind nmcu_top nmcu_sva u_sva (
    .clk(clk),
    .rst(rst),
    .mem_sel(mem_sel),
    .mem_w(mem_w),
    .ready(ready),
    .addr(addr),
    .done(done)
);

`default_nettype wire

/* sim/nmcu_tb.sv */
`default_nettype none

`include "nmcu_consts.svh"

module nmcu_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [31:0] SEED       = 32'hd30c_d86b;
    localparam int          DONE_LIMIT = 20000;
    localparam int          ACK_LIMIT  = 100;

    // layer type codes of the descriptor word
    localparam logic [1:0] T_NOP  = 2'd0;
    localparam logic [1:0] T_RSVD = 2'd1;
    localparam logic [1:0] T_MAXP = 2'd2;
    localparam logic [1:0] T_RELU = 2'd3;

    logic                    clk;
    logic                    rst;
    logic                    start;
    logic                    done;
    logic [`NMCU_ADDR_W-1:0] desc_addr;
    logic [`NMCU_ADDR_W-1:0] input_addr;
    logic [`NMCU_ADDR_W-1:0] output_addr;
    logic [`NMCU_DIM_W-1:0]  full_input_width;
    logic [`NMCU_ADDR_W-1:0] addr;
    logic                    mem_sel;
    logic                    mem_w;
    logic [`NMCU_DATA_W-1:0] wr_data;
    logic [`NMCU_DATA_W-1:0] rd_data;
    logic                    ready;

    logic [`NMCU_DATA_W-1:0] mem [0:65535];
    int                      stall_tab [0:255];
    logic [7:0]              stall_ptr;
    logic [`NMCU_ADDR_W-1:0] req_addr;
    logic                    req_w;
    logic [`NMCU_DATA_W-1:0] req_data;

    logic signed [31:0]      exp_tile [0:14][0:14];
    int                      exp_h;
    int                      exp_w;
    int                      errors;
    int                      failed_tests;
    int                      test_num;
    string                   test_name;
    logic                    check_req;
    logic                    check_ack;

    nmcu_top UUT (
        .clk(clk),
        .rst(rst),
        .start(start),
        .done(done),
        .desc_addr(desc_addr),
        .input_addr(input_addr),
        .output_addr(output_addr),
        .full_input_width(full_input_width),
        .addr(addr),
        .mem_sel(mem_sel),
        .mem_w(mem_w),
        .wr_data(wr_data),
        .rd_data(rd_data),
        .ready(ready)
    );

    initial begin : clock_gen
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    // word memory, answers each request after a random number of wait cycles
    initial begin : memory_model
        int   stall;
        logic pending;
        ready     = 1'b0;
        rd_data   = '0;
        stall     = 0;
        pending   = 1'b0;
        stall_ptr = 8'd0;
        forever begin
            @(posedge clk);
            #1;
            if (ready) begin
                // transfer took place on this edge
                if (req_w) begin
                    mem[req_addr] = req_data;
                end
                ready   = 1'b0;
                pending = 1'b0;
            end else if (mem_sel && !rst) begin
                if (!pending) begin
                    stall     = stall_tab[stall_ptr];
                    stall_ptr = stall_ptr + 8'd1;
                    pending   = 1'b1;
                end
                if (stall == 0) begin
                    req_addr = addr;
                    req_w    = mem_w;
                    req_data = wr_data;
                    rd_data  = mem[addr];
                    ready    = 1'b1;
                end else begin
                    stall = stall - 1;
                end
            end else begin
                pending = 1'b0;
            end
        end
    end

    function automatic logic [31:0] make_desc(input logic [1:0] kind, input int h, input int w);
        return {22'd0, 4'(h), 4'(w), kind};
    endfunction

    task automatic set_desc(input int slot, input logic [1:0] kind, input int h, input int w);
        mem[desc_addr + 16'(slot)] = make_desc(kind, h, w);
    endtask

    task automatic fill_image(input logic [15:0] base, input int rows, input int cols);
        int r;
        int c;
        for (r = 0; r < rows; r++) begin
            for (c = 0; c < cols; c++) begin
                mem[base + 16'(r * cols + c)] = $urandom;
            end
        end
    endtask

    // expected output tile from the descriptor list and the stored image
    function automatic void compute_expected();
        logic signed [31:0] a [0:14][0:14];
        logic signed [31:0] b [0:14][0:14];
        logic [31:0]        d [0:7];
        logic signed [31:0] m;
        int                 term;
        int                 h;
        int                 w;
        int                 i;
        int                 r;
        int                 c;
        term = 7;
        // scanning downward leaves the first terminator
        for (i = 7; i >= 0; i--) begin
            d[i] = mem[desc_addr + 16'(i)];
            if (d[i][1:0] == T_NOP || d[i][1:0] == T_RSVD) begin
                term = i;
            end
        end
        h = int'(d[0][9:6]);
        w = int'(d[0][5:2]);
        for (r = 0; r < h; r++) begin
            for (c = 0; c < w; c++) begin
                a[r][c] = mem[input_addr + 16'(r * int'(full_input_width) + c)];
            end
        end
        for (i = 0; i < term; i++) begin
            if (d[i][1:0] == T_RELU) begin
                h = int'(d[i][9:6]);
                w = int'(d[i][5:2]);
                for (r = 0; r < h; r++) begin
                    for (c = 0; c < w; c++) begin
                        b[r][c] = (a[r][c] < 0) ? 32'sd0 : a[r][c];
                    end
                end
            end else begin
                // pooled shape comes from the following descriptor
                h = int'(d[i + 1][9:6]);
                w = int'(d[i + 1][5:2]);
                for (r = 0; r < h; r++) begin
                    for (c = 0; c < w; c++) begin
                        m = a[2 * r][2 * c];
                        if (a[2 * r][2 * c + 1] > m) begin
                            m = a[2 * r][2 * c + 1];
                        end
                        if (a[2 * r + 1][2 * c] > m) begin
                            m = a[2 * r + 1][2 * c];
                        end
                        if (a[2 * r + 1][2 * c + 1] > m) begin
                            m = a[2 * r + 1][2 * c + 1];
                        end
                        b[r][c] = m;
                    end
                end
            end
            a = b;
        end
        exp_h    = int'(d[term][9:6]);
        exp_w    = int'(d[term][5:2]);
        exp_tile = a;
    endfunction

    always @(posedge clk) begin : compare
        int          r;
        int          c;
        int          bad;
        logic [15:0] a;
        if (check_req && !check_ack) begin
            compute_expected();
            bad = 0;
            for (r = 0; r < exp_h; r++) begin
                for (c = 0; c < exp_w; c++) begin
                    a = output_addr + 16'(r * exp_w + c);
                    if (mem[a] !== exp_tile[r][c]) begin
                        $display("MISMATCH wr_data/memory[%04h]: got %08h, expected %08h",
                                 a, mem[a], exp_tile[r][c]);
                        bad++;
                    end
                end
            end
            errors += bad;
            if (bad != 0) begin
                failed_tests++;
            end
            $display("test %0d %s: %0d words checked, %0d mismatches",
                     test_num, test_name, exp_h * exp_w, bad);
            check_ack = 1'b1;
        end
    end

    task automatic run_test(input string name);
        int cycles;
        test_num++;
        test_name = name;
        @(posedge clk);
        #1 rst = 1'b1;
        repeat (8) @(posedge clk);
        #1 rst = 1'b0;
        @(posedge clk);
        #1 start = 1'b1;
        @(posedge clk);
        #1 start = 1'b0;
        cycles = 0;
        while (!done && cycles < DONE_LIMIT) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (!done) begin
            $display("test %0d %s: timed out waiting for done", test_num, name);
            errors++;
            failed_tests++;
        end else begin
            check_req = 1'b1;
            cycles = 0;
            while (!check_ack && cycles < ACK_LIMIT) begin
                @(posedge clk);
                #1;
                cycles++;
            end
            if (!check_ack) begin
                $display("test %0d %s: output compare never finished", test_num, name);
                errors++;
                failed_tests++;
            end
            check_req = 1'b0;
            check_ack = 1'b0;
        end
    endtask

    initial begin : stimulus
        logic [31:0] seed_out;
        int          i;
        rst              = 1'b1;
        start            = 1'b0;
        desc_addr        = '0;
        input_addr       = '0;
        output_addr      = '0;
        full_input_width = '0;
        check_req        = 1'b0;
        check_ack        = 1'b0;
        errors           = 0;
        failed_tests     = 0;
        test_num         = 0;
        seed_out = $urandom(SEED);
        for (i = 0; i < 65536; i++) begin
            mem[i] = {~16'(i), 16'(i)};
        end
        for (i = 0; i < 256; i++) begin
            stall_tab[i] = $urandom % 4;
        end

        // 5x7 tile out of a 12-wide image, copied unchanged
        full_input_width = 4'd12;
        desc_addr = 16'h0100;
        input_addr = 16'h1000;
        output_addr = 16'h8000;
        set_desc(0, T_NOP, 5, 7);
        fill_image(input_addr, 5, 12);
        run_test("strided copy");

        full_input_width = 4'd9;
        desc_addr = 16'h0200;
        input_addr = 16'h2000;
        output_addr = 16'h8100;
        set_desc(0, T_RELU, 6, 9);
        set_desc(1, T_NOP, 6, 9);
        fill_image(input_addr, 6, 9);
        run_test("relu");

        full_input_width = 4'd10;
        desc_addr = 16'h0300;
        input_addr = 16'h3000;
        output_addr = 16'h8200;
        set_desc(0, T_MAXP, 8, 6);
        set_desc(1, T_NOP, 4, 3);
        fill_image(input_addr, 8, 10);
        run_test("max-pool even");

        // odd sides, last row and column are dropped
        full_input_width = 4'd5;
        desc_addr = 16'h0380;
        input_addr = 16'h3800;
        output_addr = 16'h8280;
        set_desc(0, T_MAXP, 7, 5);
        set_desc(1, T_NOP, 3, 2);
        fill_image(input_addr, 7, 5);
        run_test("max-pool odd");

        full_input_width = 4'd13;
        desc_addr = 16'h0400;
        input_addr = 16'h4000;
        output_addr = 16'h8300;
        set_desc(0, T_RELU, 9, 7);
        set_desc(1, T_MAXP, 9, 7);
        set_desc(2, T_RELU, 4, 3);
        set_desc(3, T_NOP, 4, 3);
        fill_image(input_addr, 9, 13);
        run_test("relu pool relu chain");

        // full list, slot 7 never runs and only gives the final shape
        // slot 6 pools, so stopping a layer early changes the result
        full_input_width = 4'd10;
        desc_addr = 16'h0500;
        input_addr = 16'h5000;
        output_addr = 16'h8400;
        set_desc(0, T_MAXP, 8, 8);
        set_desc(1, T_RELU, 4, 4);
        set_desc(2, T_RELU, 4, 4);
        set_desc(3, T_RELU, 4, 4);
        set_desc(4, T_RELU, 4, 4);
        set_desc(5, T_RELU, 4, 4);
        set_desc(6, T_MAXP, 4, 4);
        set_desc(7, T_MAXP, 2, 2);
        set_desc(8, T_RELU, 1, 1);
        fill_image(input_addr, 8, 10);
        run_test("eight descriptors");

        full_input_width = 4'd8;
        desc_addr = 16'h0600;
        input_addr = 16'h6000;
        output_addr = 16'h8500;
        set_desc(0, T_RELU, 6, 6);
        set_desc(1, T_MAXP, 6, 6);
        set_desc(2, T_RSVD, 3, 3);
        set_desc(3, T_MAXP, 3, 3);
        set_desc(4, T_NOP, 1, 1);
        fill_image(input_addr, 6, 8);
        run_test("reserved terminator");

        $display("%0d tests run, %0d failed, %0d errors", test_num, failed_tests, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
+incdir+include
hdl/nmcu_pkg.sv
hdl/nmcu_desc_store.sv
hdl/nmcu_act_buffer.sv
hdl/nmcu_layer_alu.sv
hdl/nmcu_ctrl.sv
hdl/nmcu_top.sv
sim/nmcu_sva.sv
sim/nmcu_tb.sv

/* Makefile */
TOOL     := verilator
FLAGS    := --binary --timing --assert --timescale 1ns/100ps
TOP      := nmcu_tb
FILELIST := sources.f
MDIR     := obj_dir
LOG      := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(MDIR)

run: compile
	./$(MDIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Errors found" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "No errors" $(LOG); then echo "simulation ended without a result"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(MDIR) $(LOG)
